//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Function fields of the supported encodings.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JUMP
    } br_kind_e;

endpackage

`default_nettype wire

//--- hdl/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    import rv_isa_pkg::*;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fd_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    op_a;
        word_t    op_b;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        br_kind_e br;
        logic     mem_rd;
        logic     mem_wr;
        logic     reg_wr;
        logic     inst_sup;
    } de_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    result;
        word_t    store_data;
        logic     mem_rd;
        logic     mem_wr;
        logic     reg_wr;
    } em_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
        logic     reg_wr;
    } mw_t;

    typedef struct packed {
        logic  req;
        logic  we;
        word_t addr;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    value;
        logic     reg_wr;
    } retire_t;

    // Each bit acts on the input register of the named stage.
    typedef struct packed {
        logic fetch_stall;
        logic decode_stall;
        logic decode_flush;
        logic exec_stall;
        logic exec_flush;
        logic mem_stall;
    } ctrl_t;

    typedef enum logic {
        MEM_IDLE,
        MEM_WAIT
    } mem_state_e;

endpackage

`default_nettype wire

//--- hdl/rv_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module rv_ctrl
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  wire           i_pc_change,
    input  wire           i_mem_ready,
    input  wire           i_dec_inst_sup,
    input  wire reg_idx_t i_dec_rs1,
    input  wire reg_idx_t i_dec_rs2,
    input  wire           i_ex_mem_rd,
    input  wire reg_idx_t i_ex_rd,
    output ctrl_t         o_ctrl,
    output logic          o_inv_inst
);

    logic       load_use;
    logic       decode_stall;
    logic       global_flush;
    logic [1:0] inst_sup_q;

    always_comb
    begin
        load_use = i_ex_mem_rd && (i_ex_rd != '0) &&
                   ((i_ex_rd == i_dec_rs1) || (i_ex_rd == i_dec_rs2));
        decode_stall = load_use || !i_mem_ready;
        // A redirect is only taken once the branch can leave execute.
        global_flush = !i_rst_n || (i_pc_change && i_mem_ready);
    end

    always_comb
    begin
        o_ctrl.fetch_stall  = decode_stall;
        o_ctrl.decode_stall = decode_stall;
        o_ctrl.decode_flush = global_flush;
        o_ctrl.exec_stall   = !i_mem_ready;
        o_ctrl.exec_flush   = global_flush || (decode_stall && i_mem_ready);
        o_ctrl.mem_stall    = !i_mem_ready;
    end

    // Supported flags of the instructions in decode and in execute.
    always_ff @(posedge i_clk)
    begin
        if (global_flush)
            inst_sup_q <= 2'b11;
        else if (!decode_stall)
            inst_sup_q <= {inst_sup_q[0], i_dec_inst_sup};
    end

    assign o_inv_inst = !inst_sup_q[1];

endmodule

`default_nettype wire

//--- hdl/rv_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module rv_fetch
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire ctrl_t i_ctrl,
    input  wire        i_pc_change,
    input  wire word_t i_target,
    output word_t      o_imem_addr,
    input  wire word_t i_imem_data,
    output fd_t        o_fd
);

    word_t pc_q;
    fd_t   fd_q;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            pc_q <= RESET_PC;
        else if (!i_ctrl.fetch_stall)
            pc_q <= i_pc_change ? i_target : pc_q + XLEN'(4);
    end

    always_ff @(posedge i_clk)
    begin
        if (i_ctrl.decode_flush)
            fd_q.valid <= 1'b0;
        else if (!i_ctrl.decode_stall)
        begin
            fd_q.valid <= 1'b1;
            fd_q.pc    <= pc_q;
            fd_q.instr <= i_imem_data;
        end
    end

    assign o_imem_addr = pc_q;
    assign o_fd        = fd_q;

endmodule

`default_nettype wire

//--- hdl/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module rv_regfile
    import rv_isa_pkg::*;
(
    input  wire           i_clk,
    input  wire           i_rst_n,
    input  wire reg_idx_t i_ra,
    input  wire reg_idx_t i_rb,
    output word_t         o_da,
    output word_t         o_db,
    input  wire           i_we,
    input  wire reg_idx_t i_wa,
    input  wire word_t    i_wd
);

    word_t regs [1:31];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_we && (i_wa != '0))
            regs[i_wa] <= i_wd;
    end

    assign o_da = (i_ra == '0) ? '0 : regs[i_ra];
    assign o_db = (i_rb == '0) ? '0 : regs[i_rb];

endmodule

`default_nettype wire

//--- hdl/rv_decode.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire ctrl_t i_ctrl,
    input  wire fd_t   i_fd,
    input  wire mw_t   i_wb,
    output reg_idx_t   o_rs1,
    output reg_idx_t   o_rs2,
    output logic       o_inst_sup,
    output de_t        o_de
);

    word_t      instr;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       sup;
    logic       use_rs1;
    logic       use_rs2;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      rf_a;
    word_t      rf_b;
    word_t      val_a;
    word_t      val_b;
    logic       wb_wr;
    de_t        dec;
    de_t        de_d;
    de_t        de_q;

    assign instr  = i_fd.instr;
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb
    begin
        dec     = '0;
        sup     = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (instr[6:0])
            OP_REG:
            begin
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                dec.reg_wr = 1'b1;
                sup        = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}: dec.alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD}:  dec.alu_op = ALU_SUB;
                    {F7_BASE, F3_SLT}: dec.alu_op = ALU_SLT;
                    {F7_BASE, F3_XOR}: dec.alu_op = ALU_XOR;
                    {F7_BASE, F3_OR}:  dec.alu_op = ALU_OR;
                    {F7_BASE, F3_AND}: dec.alu_op = ALU_AND;
                    default:           sup = 1'b0;
                endcase
            end
            OP_IMM, OP_LOAD:
            begin
                use_rs1     = 1'b1;
                dec.use_imm = 1'b1;
                dec.reg_wr  = 1'b1;
                dec.mem_rd  = (instr[6:0] == OP_LOAD);
                dec.imm     = {{20{instr[31]}}, instr[31:20]};
                sup         = (funct3 == (dec.mem_rd ? F3_WORD : F3_ADD));
            end
            OP_STORE:
            begin
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                dec.use_imm = 1'b1;
                dec.mem_wr  = 1'b1;
                dec.imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                sup         = (funct3 == F3_WORD);
            end
            OP_BRANCH:
            begin
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
                dec.alu_op = ALU_SUB;
                dec.br     = (funct3 == F3_BNE) ? BR_NE : BR_EQ;
                dec.imm    = {{19{instr[31]}}, instr[31], instr[7],
                              instr[30:25], instr[11:8], 1'b0};
                sup        = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            end
            OP_JAL:
            begin
                dec.alu_op = ALU_PASS_B;
                dec.br     = BR_JUMP;
                dec.reg_wr = 1'b1;
                dec.imm    = {{11{instr[31]}}, instr[31], instr[19:12],
                              instr[20], instr[30:21], 1'b0};
                sup        = 1'b1;
            end
            default:
            begin
                sup = 1'b0;
            end
        endcase
    end

    // Unused source fields read as x0 so they never match a producer.
    assign rs1   = (i_fd.valid && use_rs1) ? instr[19:15] : '0;
    assign rs2   = (i_fd.valid && use_rs2) ? instr[24:20] : '0;
    assign wb_wr = i_wb.valid && i_wb.reg_wr;

    rv_regfile regfile_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ra    (rs1),
        .i_rb    (rs2),
        .o_da    (rf_a),
        .o_db    (rf_b),
        .i_we    (wb_wr),
        .i_wa    (i_wb.rd),
        .i_wd    (i_wb.value)
    );

    assign val_a = (wb_wr && (rs1 != '0) && (i_wb.rd == rs1)) ? i_wb.value : rf_a;
    assign val_b = (wb_wr && (rs2 != '0) && (i_wb.rd == rs2)) ? i_wb.value : rf_b;

    always_comb
    begin
        de_d          = dec;
        de_d.valid    = i_fd.valid;
        de_d.pc       = i_fd.pc;
        de_d.rs1      = rs1;
        de_d.rs2      = rs2;
        de_d.rd       = instr[11:7];
        de_d.op_a     = val_a;
        // JAL carries its link value in the second operand.
        de_d.op_b     = (dec.br == BR_JUMP) ? i_fd.pc + XLEN'(4) : val_b;
        de_d.inst_sup = sup;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n || i_ctrl.exec_flush)
            de_q.valid <= 1'b0;
        else if (!i_ctrl.exec_stall)
            de_q <= de_d;
    end

    assign o_rs1      = rs1;
    assign o_rs2      = rs2;
    assign o_inst_sup = !i_fd.valid || sup;
    assign o_de       = de_q;

endmodule

`default_nettype wire

//--- hdl/rv_execute.sv
`timescale 1ns/1ns
`default_nettype none

module rv_execute
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire ctrl_t i_ctrl,
    input  wire de_t   i_de,
    input  wire em_t   i_mem_fwd,
    input  wire mw_t   i_wb_fwd,
    output reg_idx_t   o_ex_rd,
    output logic       o_ex_mem_rd,
    output logic       o_pc_change,
    output word_t      o_target,
    output em_t        o_em
);

    logic  live;
    logic  taken;
    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t result;
    em_t   em_q;

    // The memory stage result wins over write-back. Loads in memory have no data yet.
    function automatic word_t fwd_sel(reg_idx_t rs, word_t rf_val, em_t em, mw_t mw);
        word_t v;
        v = rf_val;
        if ((rs != '0) && mw.reg_wr && (mw.rd == rs))
            v = mw.value;
        if ((rs != '0) && em.reg_wr && !em.mem_rd && (em.rd == rs))
            v = em.result;
        return v;
    endfunction

    always_comb
    begin
        live  = i_de.valid && i_de.inst_sup;
        op_a  = fwd_sel(i_de.rs1, i_de.op_a, i_mem_fwd, i_wb_fwd);
        op_b  = fwd_sel(i_de.rs2, i_de.op_b, i_mem_fwd, i_wb_fwd);
        alu_b = i_de.use_imm ? i_de.imm : op_b;
        case (i_de.alu_op)
            ALU_ADD:    result = op_a + alu_b;
            ALU_SUB:    result = op_a - alu_b;
            ALU_AND:    result = op_a & alu_b;
            ALU_OR:     result = op_a | alu_b;
            ALU_XOR:    result = op_a ^ alu_b;
            ALU_SLT:    result = XLEN'($signed(op_a) < $signed(alu_b));
            ALU_PASS_B: result = alu_b;
            default:    result = '0;
        endcase
        case (i_de.br)
            BR_EQ:   taken = (op_a == op_b);
            BR_NE:   taken = (op_a != op_b);
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            em_q.valid  <= 1'b0;
            em_q.mem_rd <= 1'b0;
            em_q.mem_wr <= 1'b0;
            em_q.reg_wr <= 1'b0;
        end
        else if (!i_ctrl.mem_stall)
        begin
            em_q.valid      <= live;
            em_q.pc         <= i_de.pc;
            em_q.rd         <= i_de.rd;
            em_q.result     <= result;
            em_q.store_data <= op_b;
            em_q.mem_rd     <= live && i_de.mem_rd;
            em_q.mem_wr     <= live && i_de.mem_wr;
            em_q.reg_wr     <= live && i_de.reg_wr;
        end
    end

    assign o_ex_rd     = i_de.rd;
    assign o_ex_mem_rd = live && i_de.mem_rd;
    assign o_pc_change = live && taken;
    assign o_target    = i_de.pc + i_de.imm;
    assign o_em        = em_q;

endmodule

`default_nettype wire

//--- hdl/rv_memory.sv
`timescale 1ns/1ns
`default_nettype none

module rv_memory
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire em_t   i_em,
    output dmem_req_t  o_dmem,
    input  wire        i_dmem_ack,
    input  wire word_t i_dmem_rdata,
    output logic       o_mem_ready,
    output mw_t        o_mw
);

    mem_state_e state_q;
    mem_state_e state_d;
    logic       access;
    logic       req;
    mw_t        mw_q;

    always_comb
    begin
        access  = i_em.valid && (i_em.mem_rd || i_em.mem_wr);
        req     = access || (state_q == MEM_WAIT);
        state_d = state_q;
        case (state_q)
            MEM_IDLE: if (access && !i_dmem_ack) state_d = MEM_WAIT;
            MEM_WAIT: if (i_dmem_ack) state_d = MEM_IDLE;
            default:  state_d = MEM_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
            state_q <= MEM_IDLE;
        else
            state_q <= state_d;
    end

    assign o_mem_ready  = !req || i_dmem_ack;
    assign o_dmem.req   = req;
    assign o_dmem.we    = i_em.mem_wr;
    assign o_dmem.addr  = i_em.result;
    assign o_dmem.wdata = i_em.store_data;

    // While waiting only valid drops. The rest stays visible to execute forwarding.
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            mw_q.valid  <= 1'b0;
            mw_q.reg_wr <= 1'b0;
        end
        else if (o_mem_ready)
        begin
            mw_q.valid  <= i_em.valid;
            mw_q.pc     <= i_em.pc;
            mw_q.rd     <= i_em.rd;
            mw_q.value  <= i_em.mem_rd ? i_dmem_rdata : i_em.result;
            mw_q.reg_wr <= i_em.reg_wr;
        end
        else
            mw_q.valid <= 1'b0;
    end

    assign o_mw = mw_q;

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    output word_t      o_imem_addr,
    input  wire word_t i_imem_data,
    output dmem_req_t  o_dmem,
    input  wire        i_dmem_ack,
    input  wire word_t i_dmem_rdata,
    output retire_t    o_retire,
    output logic       o_inv_inst
);

    ctrl_t    ctrl;
    fd_t      fd;
    de_t      de;
    em_t      em;
    mw_t      mw;
    logic     pc_change;
    word_t    target;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    logic     dec_inst_sup;
    reg_idx_t ex_rd;
    logic     ex_mem_rd;
    logic     mem_ready;

    rv_ctrl ctrl_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_pc_change(pc_change),
        .i_mem_ready(mem_ready), .i_dec_inst_sup(dec_inst_sup),
        .i_dec_rs1(dec_rs1), .i_dec_rs2(dec_rs2), .i_ex_mem_rd(ex_mem_rd),
        .i_ex_rd(ex_rd), .o_ctrl(ctrl), .o_inv_inst(o_inv_inst)
    );

    rv_fetch fetch_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_ctrl(ctrl), .i_pc_change(pc_change),
        .i_target(target), .o_imem_addr(o_imem_addr), .i_imem_data(i_imem_data),
        .o_fd(fd)
    );

    rv_decode decode_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_ctrl(ctrl), .i_fd(fd), .i_wb(mw),
        .o_rs1(dec_rs1), .o_rs2(dec_rs2), .o_inst_sup(dec_inst_sup), .o_de(de)
    );

    rv_execute execute_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_ctrl(ctrl), .i_de(de),
        .i_mem_fwd(em), .i_wb_fwd(mw), .o_ex_rd(ex_rd), .o_ex_mem_rd(ex_mem_rd),
        .o_pc_change(pc_change), .o_target(target), .o_em(em)
    );

    rv_memory memory_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_em(em), .o_dmem(o_dmem),
        .i_dmem_ack(i_dmem_ack), .i_dmem_rdata(i_dmem_rdata),
        .o_mem_ready(mem_ready), .o_mw(mw)
    );

    assign o_retire.valid  = mw.valid;
    assign o_retire.pc     = mw.pc;
    assign o_retire.rd     = mw.rd;
    assign o_retire.value  = mw.value;
    assign o_retire.reg_wr = mw.reg_wr;

endmodule

`default_nettype wire

//--- verif/rv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
();

    logic      i_clk;
    logic      i_rst_n;
    word_t     o_imem_addr;
    word_t     i_imem_data;
    dmem_req_t o_dmem;
    logic      i_dmem_ack;
    word_t     i_dmem_rdata;
    retire_t   o_retire;
    logic      o_inv_inst;

    word_t       case_mem [0:255];
    word_t       imem [0:63];
    word_t       dmem [0:63];
    logic [31:0] lfsr_q;
    int          n_prog;
    int          n_init;
    int          n_rec;
    int          n_chk;
    int          rec_idx;
    int          cycles;
    int          limit;
    logic        dmem_busy;
    int          dmem_wait;
    logic        inv_seen;

    rv_core rv_core_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .o_imem_addr  (o_imem_addr),
        .i_imem_data  (i_imem_data),
        .o_dmem       (o_dmem),
        .i_dmem_ack   (i_dmem_ack),
        .i_dmem_rdata (i_dmem_rdata),
        .o_retire     (o_retire),
        .o_inv_inst   (o_inv_inst)
    );

    always #10 i_clk = ~i_clk;

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "Run aborted.");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // Records are pc, rd, value and reg_wr. Stores and branches write no register.
    task automatic check_retire(input retire_t got);
        int      base;
        retire_t exp;
        base       = 'h50 + rec_idx * 4;
        exp.valid  = 1'b1;
        exp.pc     = case_mem[base];
        exp.rd     = case_mem[base + 1][4:0];
        exp.value  = case_mem[base + 2];
        exp.reg_wr = case_mem[base + 3][0];
        check_word("o_retire.pc", got.pc, exp.pc);
        check_word("o_retire.reg_wr", got.reg_wr, exp.reg_wr);
        if (exp.reg_wr)
        begin
            check_word("o_retire.rd", got.rd, exp.rd);
            check_word("o_retire.value", got.value, exp.value);
        end
        rec_idx++;
    endtask

    task automatic load_cases();
        for (int i = 0; i < 256; i++)
            case_mem[i] = '0;
        $readmemh("verif/rv_core_cases.hex", case_mem);
        n_prog = case_mem[0];
        n_init = case_mem[1];
        n_rec  = case_mem[2];
        n_chk  = case_mem[3];
        if (n_rec == 0)
        begin
            $display("The cases file holds no expected retirement records.");
            stop_with_failure();
        end
        for (int i = 0; i < 64; i++)
        begin
            imem[i] = 32'h0000_0013;
            dmem[i] = 32'hd00d_0000 ^ (i << 2);
        end
        for (int i = 0; i < n_prog; i++)
            imem[i] = case_mem['h10 + i];
        for (int i = 0; i < n_init; i++)
            dmem[case_mem['h40 + 2 * i][7:2]] = case_mem['h41 + 2 * i];
    endtask

    task automatic drive_fetch();
        if (o_imem_addr[31:8] == '0)
            i_imem_data = imem[o_imem_addr[7:2]];
        else
            i_imem_data = 32'h0000_0013;
    endtask

    // Each access gets a fresh delay of zero to three cycles before its ack.
    task automatic serve_dmem();
        i_dmem_ack   = 1'b0;
        i_dmem_rdata = '0;
        if (o_dmem.req)
        begin
            if (o_dmem.addr[31:8] != '0)
            begin
                $display("Data access outside the memory model at address %h.", o_dmem.addr);
                stop_with_failure();
            end
            if (!dmem_busy)
            begin
                dmem_busy = 1'b1;
                dmem_wait = 0;
                for (int b = 0; b < 2; b++)
                begin
                    dmem_wait = (dmem_wait << 1) | lfsr_q[0];
                    lfsr_q    = lfsr_next(lfsr_q);
                end
            end
            if (dmem_wait == 0)
            begin
                i_dmem_ack = 1'b1;
                dmem_busy  = 1'b0;
                if (o_dmem.we)
                    dmem[o_dmem.addr[7:2]] = o_dmem.wdata;
                else
                    i_dmem_rdata = dmem[o_dmem.addr[7:2]];
            end
            else
                dmem_wait--;
        end
    endtask

    task automatic check_final_memory();
        word_t addr;
        for (int k = 0; k < n_chk; k++)
        begin
            addr = case_mem['hb0 + 2 * k];
            check_word($sformatf("dmem[%h]", addr), dmem[addr[7:2]], case_mem['hb1 + 2 * k]);
        end
    endtask

    initial
    begin
        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_imem_data  = '0;
        i_dmem_ack   = 1'b0;
        i_dmem_rdata = '0;
        lfsr_q       = 32'ha75e_5b15;
        rec_idx      = 0;
        cycles       = 0;
        dmem_busy    = 1'b0;
        dmem_wait    = 0;
        inv_seen     = 1'b0;
        load_cases();
        limit = n_rec * 8 + 200;
        repeat (10)
        begin
            @(posedge i_clk);
            #2;
            drive_fetch();
        end
        check_word("o_imem_addr", o_imem_addr, RESET_PC);
        check_word("o_dmem.req", o_dmem.req, 32'h0);
        check_word("o_retire.valid", o_retire.valid, 32'h0);
        check_word("o_inv_inst", o_inv_inst, 32'h0);
        i_rst_n = 1'b1;
        while (rec_idx < n_rec)
        begin
            @(posedge i_clk);
            #2;
            cycles++;
            if (cycles > limit)
            begin
                $display("Timeout after %0d cycles with %0d of %0d records retired.",
                         cycles, rec_idx, n_rec);
                stop_with_failure();
            end
            if (o_retire.valid)
                check_retire(o_retire);
            if (o_inv_inst)
                inv_seen = 1'b1;
            serve_dmem();
            drive_fetch();
        end
        check_word("o_dmem.req", o_dmem.req, 32'h0);
        check_final_memory();
        if (!inv_seen)
        begin
            $display("The unsupported instruction never raised o_inv_inst.");
            stop_with_failure();
        end
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- list.f
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_ctrl.sv
hdl/rv_fetch.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/rv_core.sv
verif/rv_core_tb.sv

//--- verif/rv_core_cases.hex
// @000 counts: program words, data init pairs, retirement records, memory checks.
// @010 program, @040 init (addr value), @050 records (pc rd value reg_wr), @0b0 checks (addr value).
@000
00000019 00000001 00000014 00000003
@010
00500093 ffd00113 002081b3 40118233 // addi x1, addi x2, add x3, sub x4
001222b3 0021c333 0032e3b3 00737433 // slt x5, xor x6, or x7, and x8
04002483 00148533 04a02223 04402583 // lw x9, add x10 (load-use), sw x10, lw x11
00a58463 06300613 00109463 00700613 // beq taken, wrong path, bne not taken, addi x12
00c006ef 00100713 00200713 000017b7 // jal x13, two wrong path, lui (unsupported)
04c02423 00069463 03700793 00028463 // sw x12, bne taken, wrong path, beq not taken
00868833                            // add x16
@040
00000040 00001000
@050
00000000 00000001 00000005 00000001
00000004 00000002 fffffffd 00000001
00000008 00000003 00000002 00000001
0000000c 00000004 fffffffd 00000001
00000010 00000005 00000001 00000001
00000014 00000006 ffffffff 00000001
00000018 00000007 00000003 00000001
0000001c 00000008 00000003 00000001
00000020 00000009 00001000 00000001
00000024 0000000a 00001005 00000001
00000028 00000000 00000000 00000000
0000002c 0000000b 00001005 00000001
00000030 00000000 00000000 00000000
00000038 00000000 00000000 00000000
0000003c 0000000c 00000007 00000001
00000040 0000000d 00000044 00000001
00000050 00000000 00000000 00000000
00000054 00000000 00000000 00000000
0000005c 00000000 00000000 00000000
00000060 00000010 00000047 00000001
@0b0
00000040 00001000
00000044 00001005
00000048 00000007
